// File: hdl/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // wishbone data path
    localparam int WB_DATA_W = 32;
    localparam int WB_SEL_W  = WB_DATA_W / 8;  // one select bit per byte
    localparam int WB_ADR_W  = 32;             // byte address at the top level

    // byte lanes
    localparam int WB_BYTE_W = WB_DATA_W / WB_SEL_W;

    // low address bits that pick a byte inside a word
    localparam int WB_WORD_OFS_W = $clog2(WB_SEL_W);

endpackage

`default_nettype wire

// File: hdl/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

    // scratch RAM slots
    localparam int NUM_SLOTS  = 4;
    localparam int SLOT_IDX_W = $clog2(NUM_SLOTS);
    localparam int RAM_WORDS  = 256;
    localparam int RAM_ADR_W  = $clog2(RAM_WORDS);  // word index inside a slot

    // address map, window is 0x0000_0000 .. 0x0000_0FFF
    localparam logic [31:0] RAM_BASE  = 32'h0000_0000;
    localparam int          SLOT_SPAN = 1024;            // bytes per slot
    localparam logic [31:0] RAM_SPAN  = 32'(NUM_SLOTS * SLOT_SPAN);

    // block RAMs need some settling time after configuration
    localparam int RESET_HOLD = 16;
    localparam int RST_CNT_W  = $clog2(RESET_HOLD + 1);

endpackage

`default_nettype wire

// File: hdl/wb_slot_if.sv
`timescale 1ns/1ns
`default_nettype none

// one decoder-to-slave bus, cyc is folded into stb by the decoder
interface wb_slot_if import wb_pkg::*, soc_map_pkg::*; ();

    logic                 stb;
    logic                 we;
    logic [RAM_ADR_W-1:0] adr;    // word index
    logic [WB_SEL_W-1:0]  sel;
    logic [WB_DATA_W-1:0] dat_w;
    logic                 ack;
    logic [WB_DATA_W-1:0] dat_r;

    modport master (
        output stb, we, adr, sel, dat_w,
        input  ack, dat_r
    );

    modport slave (
        input  stb, we, adr, sel, dat_w,
        output ack, dat_r
    );

    // response side only
    modport monitor (
        input ack, dat_r
    );

endinterface

`default_nettype wire

// File: hdl/reset_stretch.sv
`timescale 1ns/1ns
`default_nettype none

module reset_stretch import soc_map_pkg::*; (
    input  logic clk,
    input  logic reset_button,  // active low
    output logic rst_o
);

    // loaded at power-up so reset is held before the first press too
    logic [RST_CNT_W-1:0] hold_cnt = RST_CNT_W'(RESET_HOLD);

    always_ff @(posedge clk) begin
        if (!reset_button) begin
            hold_cnt <= RST_CNT_W'(RESET_HOLD);  // reload while pressed
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign rst_o = (hold_cnt != '0);

endmodule

`default_nettype wire

// File: hdl/wb_addr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module wb_addr_decoder import wb_pkg::*, soc_map_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 cyc_i,
    input  logic                 stb_i,
    input  logic                 we_i,
    input  logic [WB_ADR_W-1:0]  adr_i,
    input  logic [WB_SEL_W-1:0]  sel_i,
    input  logic [WB_DATA_W-1:0] dat_i,
    output logic                 err_o,
    output logic [NUM_SLOTS-1:0] slot_sel_o,
    wb_slot_if.master            slots [NUM_SLOTS]
);

    logic [WB_ADR_W-1:0]   offset;
    logic                  in_window;
    logic [SLOT_IDX_W-1:0] slot_idx;
    logic [RAM_ADR_W-1:0]  word_idx;
    logic                  req;
    logic                  err_q;

    // below RAM_BASE the subtraction wraps, so one compare covers both ends
    assign offset    = adr_i - RAM_BASE;
    assign in_window = (offset < RAM_SPAN);
    assign slot_idx  = offset[WB_WORD_OFS_W + RAM_ADR_W +: SLOT_IDX_W];
    assign word_idx  = offset[WB_WORD_OFS_W +: RAM_ADR_W];
    assign req       = cyc_i & stb_i;

    for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_slot
        assign slot_sel_o[g] = in_window && (slot_idx == SLOT_IDX_W'(g));

        // strobe only to the hit slot, the rest is broadcast
        assign slots[g].stb   = req & slot_sel_o[g];
        assign slots[g].we    = we_i;
        assign slots[g].adr   = word_idx;
        assign slots[g].sel   = sel_i;
        assign slots[g].dat_w = dat_i;
    end

    // unmapped cycle, answered with err one clock later like a RAM ack
    always_ff @(posedge clk) begin
        if (rst_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req & ~in_window & ~err_q;  // single pulse per cycle
        end
    end

    assign err_o = err_q;

endmodule

`default_nettype wire

// File: hdl/scratch_ram_wb.sv
`timescale 1ns/1ns
`default_nettype none

module scratch_ram_wb import wb_pkg::*, soc_map_pkg::*; (
    input  logic     clk,
    input  logic     rst_i,
    wb_slot_if.slave bus
);

    logic [WB_DATA_W-1:0] mem [RAM_WORDS];
    logic [WB_DATA_W-1:0] dat_q;
    logic                 ack_q;
    logic                 serve;

    // take a strobe once, the ack cycle itself is not a new request
    assign serve = bus.stb & ~ack_q & ~rst_i;

    always_ff @(posedge clk) begin
        if (serve) begin
            if (bus.we) begin
                for (int b = 0; b < WB_SEL_W; b++) begin
                    if (bus.sel[b]) begin
                        mem[bus.adr][b*WB_BYTE_W +: WB_BYTE_W] <=
                            bus.dat_w[b*WB_BYTE_W +: WB_BYTE_W];
                    end
                end
            end
            dat_q <= mem[bus.adr];  // old word, also on writes
        end
    end

    // ack follows the sampled strobe by one clock
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus.stb & ~ack_q;
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = dat_q;

endmodule

`default_nettype wire

// File: hdl/wb_response_mux.sv
`timescale 1ns/1ns
`default_nettype none

module wb_response_mux import wb_pkg::*, soc_map_pkg::*; (
    input  logic [NUM_SLOTS-1:0] slot_sel_i,  // one-hot from the decoder
    wb_slot_if.monitor           slots [NUM_SLOTS],
    output logic [WB_DATA_W-1:0] dat_o,
    output logic                 ack_o
);

    logic [NUM_SLOTS-1:0] ack_v;
    logic [WB_DATA_W-1:0] dat_v [NUM_SLOTS];

    // flatten the interface array, it needs constant indices
    for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_gather
        assign ack_v[g] = slots[g].ack;
        assign dat_v[g] = slots[g].dat_r;
    end

    assign ack_o = |(ack_v & slot_sel_i);

    // and-or select, zero when nothing is hit
    always_comb begin
        dat_o = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (slot_sel_i[i]) begin
                dat_o = dat_o | dat_v[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/soc_fabric_top.sv
`timescale 1ns/1ns
`default_nettype none

module soc_fabric_top import wb_pkg::*, soc_map_pkg::*; (
    input  logic                 clk,
    input  logic                 reset_button,  // active low
    // wishbone classic slave port toward the external master
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [WB_ADR_W-1:0]  wb_adr_i,
    input  logic [WB_SEL_W-1:0]  wb_sel_i,
    input  logic [WB_DATA_W-1:0] wb_dat_i,
    output logic [WB_DATA_W-1:0] wb_dat_o,
    output logic                 wb_ack_o,
    output logic                 wb_err_o
);

    logic                 rst;       // stretched, active high
    logic [NUM_SLOTS-1:0] slot_sel;

    wb_slot_if slot_bus [NUM_SLOTS] ();

    reset_stretch u_reset (
        .clk          (clk),
        .reset_button (reset_button),
        .rst_o        (rst)
    );

    wb_addr_decoder u_decoder (
        .clk        (clk),
        .rst_i      (rst),
        .cyc_i      (wb_cyc_i),
        .stb_i      (wb_stb_i),
        .we_i       (wb_we_i),
        .adr_i      (wb_adr_i),
        .sel_i      (wb_sel_i),
        .dat_i      (wb_dat_i),
        .err_o      (wb_err_o),
        .slot_sel_o (slot_sel),
        .slots      (slot_bus)
    );

    // four identical 1 KB scratch RAMs
    for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_ram
        scratch_ram_wb u_ram (
            .clk   (clk),
            .rst_i (rst),
            .bus   (slot_bus[g])
        );
    end

    wb_response_mux u_mux (
        .slot_sel_i (slot_sel),
        .slots      (slot_bus),
        .dat_o      (wb_dat_o),
        .ack_o      (wb_ack_o)
    );

endmodule

`default_nettype wire

// File: verification/tb_soc_fabric.sv
`timescale 1ns/1ns
`default_nettype none

module tb_soc_fabric import wb_pkg::*, soc_map_pkg::*; ();

    localparam int          MODEL_WORDS  = NUM_SLOTS * RAM_WORDS;
    localparam int          NUM_RANDOM   = 400;
    localparam int          MAX_WAIT     = 64;   // negedges before a cycle is given up
    localparam int          HOT_WORDS    = 16;   // random traffic stays on a few words per slot
    localparam logic [31:0] WINDOW_BYTES = 32'(NUM_SLOTS * SLOT_SPAN);

    logic                 clk;
    logic                 reset_button;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [WB_ADR_W-1:0]  wb_adr;
    logic [WB_SEL_W-1:0]  wb_sel;
    logic [WB_DATA_W-1:0] wb_dat_w;
    logic [WB_DATA_W-1:0] wb_dat_r;
    logic                 wb_ack;
    logic                 wb_err;

    logic [WB_DATA_W-1:0] model_mem [MODEL_WORDS];
    logic                 written   [MODEL_WORDS];  // words never written are not compared
    logic [31:0]          rng;

    soc_fabric_top uut (
        .clk          (clk),
        .reset_button (reset_button),
        .wb_cyc_i     (wb_cyc),
        .wb_stb_i     (wb_stb),
        .wb_we_i      (wb_we),
        .wb_adr_i     (wb_adr),
        .wb_sel_i     (wb_sel),
        .wb_dat_i     (wb_dat_w),
        .wb_dat_o     (wb_dat_r),
        .wb_ack_o     (wb_ack),
        .wb_err_o     (wb_err)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // mapped when the address falls inside one of the slot spans
    function automatic logic in_ram_window(input logic [WB_ADR_W-1:0] adr);
        logic [31:0] slot_lo;
        logic        hit;
        hit = 1'b0;
        for (int n = 0; n < NUM_SLOTS; n++) begin
            slot_lo = RAM_BASE + 32'(n * SLOT_SPAN);
            if (adr >= slot_lo && (adr - slot_lo) < 32'(SLOT_SPAN)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // slot from the 1 KB span, word from the byte offset inside it
    function automatic int model_index(input logic [WB_ADR_W-1:0] adr);
        logic [31:0] offset;
        offset = adr - RAM_BASE;
        return int'(offset / SLOT_SPAN) * RAM_WORDS + int'((offset % SLOT_SPAN) / WB_SEL_W);
    endfunction

    function automatic logic [WB_DATA_W-1:0] merge_lanes(input logic [WB_DATA_W-1:0] old_w,
                                                         input logic [WB_DATA_W-1:0] new_w,
                                                         input logic [WB_SEL_W-1:0] sel);
        logic [WB_DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < WB_SEL_W; b++) begin
            if (sel[b]) begin
                res[b*WB_BYTE_W +: WB_BYTE_W] = new_w[b*WB_BYTE_W +: WB_BYTE_W];
            end
        end
        return res;
    endfunction

    function automatic logic [WB_ADR_W-1:0] mapped_address();
        logic [31:0] r;
        r = next_random();
        return RAM_BASE + (r % NUM_SLOTS) * SLOT_SPAN + ((r >> 8) % HOT_WORDS) * WB_SEL_W;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got %h, expected %h", name, actual, expected);
            $display("Test failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    // one classic cycle held until ack or err and then dropped
    task automatic bus_cycle(input logic we, input logic [WB_ADR_W-1:0] adr,
                             input logic [WB_SEL_W-1:0] sel, input logic [WB_DATA_W-1:0] dat,
                             output logic [WB_DATA_W-1:0] rdata, output logic got_err,
                             output int latency);
        int n;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_sel   <= sel;
        wb_dat_w <= dat;
        @(negedge clk);
        n = 1;
        while (!wb_ack && !wb_err && n < MAX_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (!wb_ack && !wb_err) begin
            $display("Test failed");
            $display("cycle to address %h timed out, the acknowledge never came", adr);
            $fatal(1, "bus timeout");
        end else begin
            rdata   = wb_dat_r;
            got_err = wb_err;
            latency = n;
            check_value("wb_ack_o and wb_err_o together", 32'(wb_ack & wb_err), 32'h0);
            @(posedge clk);
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            @(negedge clk);  // response is one clock wide
            check_value("wb_ack_o", 32'(wb_ack), 32'h0);
            check_value("wb_err_o", 32'(wb_err), 32'h0);
        end
    endtask

    task automatic write_word(input logic [WB_ADR_W-1:0] adr, input logic [WB_SEL_W-1:0] sel,
                              input logic [WB_DATA_W-1:0] dat, input int exp_latency);
        logic [WB_DATA_W-1:0] rdata;
        logic                 got_err;
        int                   latency;
        int                   idx;
        bus_cycle(1'b1, adr, sel, dat, rdata, got_err, latency);
        check_value("write latency", 32'(latency), 32'(exp_latency));
        if (in_ram_window(adr)) begin
            check_value("wb_err_o", 32'(got_err), 32'h0);
            idx            = model_index(adr);
            model_mem[idx] = merge_lanes(model_mem[idx], dat, sel);
            written[idx]   = 1'b1;
        end else begin
            check_value("wb_err_o", 32'(got_err), 32'h1);  // model stays as it is
        end
    endtask

    task automatic read_word(input logic [WB_ADR_W-1:0] adr);
        logic [WB_DATA_W-1:0] rdata;
        logic                 got_err;
        int                   latency;
        int                   idx;
        bus_cycle(1'b0, adr, '1, '0, rdata, got_err, latency);
        check_value("read latency", 32'(latency), 32'd2);
        check_value("wb_err_o", 32'(got_err), 32'(!in_ram_window(adr)));
        if (in_ram_window(adr)) begin
            idx = model_index(adr);
            if (written[idx]) begin
                check_value("wb_dat_o", rdata, model_mem[idx]);
            end
        end
    endtask

    task automatic random_transaction();
        logic [31:0]         r;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_SEL_W-1:0] sel;
        r = next_random();
        if (r[3:0] < 4'd2) begin
            // unmapped write and a read of the word it would alias
            adr = mapped_address() + WINDOW_BYTES * (1 + (next_random() % 4096));
            write_word(adr, r[7:4], next_random(), 2);
            read_word(RAM_BASE + ((adr - RAM_BASE) % WINDOW_BYTES));
        end else if (r[3:0] < 4'd9) begin
            read_word(mapped_address());
        end else begin
            adr = mapped_address();
            sel = r[7:4];
            if (sel == '0 || !written[model_index(adr)]) begin
                sel = '1;  // no known old bytes to merge with
            end
            write_word(adr, sel, next_random(), 2);
        end
    endtask

    initial begin
        logic [WB_ADR_W-1:0] adr;
        logic [31:0]         r;
        reset_button <= 1'b0;
        wb_cyc       <= 1'b0;
        wb_stb       <= 1'b0;
        wb_we        <= 1'b0;
        wb_adr       <= '0;
        wb_sel       <= '0;
        wb_dat_w     <= '0;
        rng = 32'hca8;
        for (int i = 0; i < MODEL_WORDS; i++) begin
            model_mem[i] = '0;
            written[i]   = 1'b0;
        end

        repeat (3) @(posedge clk);
        reset_button <= 1'b1;

        // strobe waits out the whole hold count plus the usual one clock
        write_word(RAM_BASE + 32'h10, '1, next_random(), RESET_HOLD + 1);
        read_word(RAM_BASE + 32'h10);

        for (int s = 0; s < NUM_SLOTS; s++) begin
            adr = RAM_BASE + 32'(s * SLOT_SPAN) + (next_random() % RAM_WORDS) * WB_SEL_W;
            write_word(adr, '1, next_random(), 2);
            read_word(adr);
            r = next_random();
            write_word(adr, r[WB_SEL_W-1:0], next_random(), 2);  // byte lanes
            read_word(adr);
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_transaction();
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/wb_pkg.sv
hdl/soc_map_pkg.sv
hdl/wb_slot_if.sv
hdl/reset_stretch.sv
hdl/wb_addr_decoder.sv
hdl/scratch_ram_wb.sv
hdl/wb_response_mux.sv
hdl/soc_fabric_top.sv
verification/tb_soc_fabric.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the Wishbone fabric testbench with Verilator and runs it
# the exit status is nonzero unless the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module tb_soc_fabric \
    -f compile.f \
    -o sim_tb_soc_fabric \
    && ./obj_dir/sim_tb_soc_fabric | tee /dev/stderr | grep -qx "Test passed" \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }
